// ==== verilog/dmem_pkg.sv ====
package dmem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int BE_W   = 4;
    localparam int ADDR_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // SRAM window from 0x8000_0000 up to 0x800F_FFFF
    localparam logic [ADDR_W-1:0] SRAM_BASE        = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] SRAM_WINDOW_MASK = 32'hFFF0_0000;

    // Word offset inside the 1 MB window is addr[19:2]
    localparam int SRAM_OFF_W = 18;

    // Implemented part of the window
    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_IDX_W = 10;

    // Scratch memory covers 0x0000_0000 to 0x0000_03FF
    localparam int SCRATCH_WORDS = 256;
    localparam int SCRATCH_IDX_W = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded target of a request
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        REGION_NONE    = 2'd0,
        REGION_SRAM    = 2'd1,
        REGION_SCRATCH = 2'd2
    } region_e;

    ////////////////////////////////////////////////////////////////////////////
    // Testbench limits
    ////////////////////////////////////////////////////////////////////////////

    // Cycles to wait for a response
    localparam int RESP_TIMEOUT = 10;

endpackage

// ==== verilog/mem_port_if.sv ====
`timescale 1ns/1ns

interface mem_port_if;

    import dmem_pkg::*;

    // Request strobe and direction
    logic                  en;
    logic                  we;
    logic [BE_W-1:0]       be;

    // Word offset, full window width so the bank can check its depth
    logic [SRAM_OFF_W-1:0] idx;
    logic [DATA_W-1:0]     wdata;

    // Registered read data, one cycle after en
    logic [DATA_W-1:0]     rdata;

    // Router side
    modport host (
        output en,
        output we,
        output be,
        output idx,
        output wdata,
        input  rdata
    );

    // Memory side
    modport bank (
        input  en,
        input  we,
        input  be,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ns

module sram_bank (
    input  logic       clk_i,
    mem_port_if.bank   port,
    output logic       range_err_o
);

    import dmem_pkg::*;

    // Storage array
    logic [DATA_W-1:0] mem [SRAM_WORDS];

    logic [SRAM_IDX_W-1:0] row;
    logic                  in_range;
    logic                  wr_en;
    logic                  rd_en;

    // Low bits pick the row and the rest must be zero
    assign row      = port.idx[SRAM_IDX_W-1:0];
    assign in_range = port.idx < SRAM_OFF_W'(SRAM_WORDS);

    // Out-of-range writes are dropped here
    assign wr_en = port.en && port.we && in_range;
    assign rd_en = port.en && !port.we;

    ////////////////////////////////////////////////////////////////////////////
    // Byte-lane writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int lane = 0; lane < BE_W; lane++) begin
                if (port.be[lane]) begin
                    mem[row][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port and depth check
    ////////////////////////////////////////////////////////////////////////////

    // Read data holds its value across writes and idle cycles
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            if (in_range) begin
                port.rdata <= mem[row];
            end else begin
                // Beyond the implemented depth reads as zero
                port.rdata <= '0;
            end
        end
    end

    // One-cycle flag for any enabled access past the end of the array
    always_ff @(posedge clk_i) begin
        range_err_o <= port.en && !in_range;
    end

endmodule

// ==== verilog/scratch_ram.sv ====
`timescale 1ns/1ns

module scratch_ram (
    input  logic     clk_i,
    mem_port_if.bank port
);

    import dmem_pkg::*;

    logic [DATA_W-1:0] mem [SCRATCH_WORDS];

    logic [SCRATCH_IDX_W-1:0] row;

    // Only the low index bits matter, the router keeps the rest zero
    assign row = port.idx[SCRATCH_IDX_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (port.en && port.we) begin
            for (int lane = 0; lane < BE_W; lane++) begin
                if (port.be[lane]) begin
                    mem[row][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////////////////////////////////////////

    // Word shows up the cycle after a read enable
    always_ff @(posedge clk_i) begin
        if (port.en && !port.we) begin
            port.rdata <= mem[row];
        end
    end

endmodule

// ==== verilog/dmem_router.sv ====
`timescale 1ns/1ns

module dmem_router (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Core-side request
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [dmem_pkg::BE_W-1:0]    be_i,
    input  logic [dmem_pkg::ADDR_W-1:0]  addr_i,
    input  logic [dmem_pkg::DATA_W-1:0]  wdata_i,

    // Core-side response
    output logic                         rvalid_o,
    output logic [dmem_pkg::DATA_W-1:0]  rdata_o,
    output logic                         err_o,

    // Memory banks
    mem_port_if.host                     sram,
    mem_port_if.host                     scratch,
    input  logic                         sram_range_err_i
);

    import dmem_pkg::*;

    region_e               region_d;
    region_e               region_q;
    logic                  rvalid_q;
    logic                  sram_hit;
    logic                  scratch_hit;
    logic [SRAM_OFF_W-1:0] word_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, request cycle
    ////////////////////////////////////////////////////////////////////////////

    // High bits must match the window base
    assign sram_hit    = (addr_i & SRAM_WINDOW_MASK) == SRAM_BASE;

    // Scratch occupies the lowest SCRATCH_WORDS words of the map
    assign scratch_hit = addr_i[ADDR_W-1:SCRATCH_IDX_W+2] == '0;

    always_comb begin
        if (sram_hit) begin
            region_d = REGION_SRAM;
        end else if (scratch_hit) begin
            region_d = REGION_SCRATCH;
        end else begin
            region_d = REGION_NONE;
        end
    end

    // Byte address to word offset, shared by both banks
    assign word_idx = addr_i[SRAM_OFF_W+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // Bank requests
    ////////////////////////////////////////////////////////////////////////////

    // Only the selected bank sees en, unmapped requests enable nothing
    assign sram.en    = req_i && (region_d == REGION_SRAM);
    assign sram.we    = we_i;
    assign sram.be    = be_i;
    assign sram.idx   = word_idx;
    assign sram.wdata = wdata_i;

    assign scratch.en    = req_i && (region_d == REGION_SCRATCH);
    assign scratch.we    = we_i;
    assign scratch.be    = be_i;
    assign scratch.idx   = word_idx;
    assign scratch.wdata = wdata_i;

    ////////////////////////////////////////////////////////////////////////////
    // Response tracking
    ////////////////////////////////////////////////////////////////////////////

    // Lines up with the one-cycle read of the banks
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
            region_q <= REGION_NONE;
        end else begin
            rvalid_q <= req_i;
            region_q <= req_i ? region_d : REGION_NONE;
        end
    end

    assign rvalid_o = rvalid_q;

    // Pick the bank that took the request, zero for unmapped
    always_comb begin
        case (region_q)
            REGION_SRAM:    rdata_o = sram.rdata;
            REGION_SCRATCH: rdata_o = scratch.rdata;
            default:        rdata_o = '0;
        endcase
    end

    // Unmapped address, or past the implemented SRAM depth
    assign err_o = rvalid_q &&
                   ((region_q == REGION_NONE) ||
                    ((region_q == REGION_SRAM) && sram_range_err_i));

endmodule

// ==== verilog/dmem_top.sv ====
`timescale 1ns/1ns

module dmem_top (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Request from the core
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [dmem_pkg::BE_W-1:0]    be_i,
    input  logic [dmem_pkg::ADDR_W-1:0]  addr_i,
    input  logic [dmem_pkg::DATA_W-1:0]  wdata_i,

    // Response to the core
    output logic                         gnt_o,
    output logic                         rvalid_o,
    output logic [dmem_pkg::DATA_W-1:0]  rdata_o,
    output logic                         err_o
);

    // One bundle per bank
    mem_port_if sram_port ();
    mem_port_if scratch_port ();

    logic sram_range_err;

    // No back-pressure, every request is taken
    assign gnt_o = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and response
    ////////////////////////////////////////////////////////////////////////////

    dmem_router u_dmem_router (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_i            (req_i),
        .we_i             (we_i),
        .be_i             (be_i),
        .addr_i           (addr_i),
        .wdata_i          (wdata_i),
        .rvalid_o         (rvalid_o),
        .rdata_o          (rdata_o),
        .err_o            (err_o),
        .sram             (sram_port.host),
        .scratch          (scratch_port.host),
        .sram_range_err_i (sram_range_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////////////////////

    // Window at 0x8000_0000
    sram_bank u_sram_bank (
        .clk_i       (clk_i),
        .port        (sram_port.bank),
        .range_err_o (sram_range_err)
    );

    // Test memory at address 0
    scratch_ram u_scratch_ram (
        .clk_i (clk_i),
        .port  (scratch_port.bank)
    );

endmodule

// ==== bench/dmem_props.sv ====
`timescale 1ns/1ns

module dmem_props (
    input logic clk_i,
    input logic reset_i,
    input logic req_i,
    input logic gnt_i,
    input logic rvalid_i,
    input logic err_i
);

    // One response per request, on the next edge
    req_then_rvalid: assert property (
        @(posedge clk_i) disable iff (reset_i) req_i |=> rvalid_i
    ) else $error("rvalid_o missing one cycle after a request");

    idle_then_quiet: assert property (
        @(posedge clk_i) disable iff (reset_i) !req_i |=> !rvalid_i
    ) else $error("rvalid_o high without a request in the previous cycle");

    err_with_rvalid: assert property (
        @(posedge clk_i) err_i |-> rvalid_i
    ) else $error("err_o high while rvalid_o is low");

    // No back-pressure
    gnt_always_high: assert property (
        @(posedge clk_i) gnt_i
    ) else $error("gnt_o dropped low");

    quiet_after_reset: assert property (
        @(posedge clk_i) $fell(reset_i) |-> !rvalid_i
    ) else $error("rvalid_o high in the cycle after reset");

endmodule

bind dmem_top dmem_props u_dmem_props (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .gnt_i    (gnt_o),
    .rvalid_i (rvalid_o),
    .err_i    (err_o)
);

// ==== bench/dmem_tb.sv ====
`timescale 1ns/1ns

module dmem_tb;

    import dmem_pkg::*;

    logic              clk_i;
    logic              reset_i;
    logic              req_i;
    logic              we_i;
    logic [BE_W-1:0]   be_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic              gnt_o;
    logic              rvalid_o;
    logic [DATA_W-1:0] rdata_o;
    logic              err_o;

    // Reference contents with one byte per entry
    logic [7:0] sram_bytes    [SRAM_WORDS*BE_W];
    logic [7:0] scratch_bytes [SCRATCH_WORDS*BE_W];

    // Expected response of the request in flight
    logic              exp_read;
    logic              exp_err;
    logic [DATA_W-1:0] exp_rdata;

    dmem_top u_dmem_top (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .err_o    (err_o)
    );

    always #5 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the memory map
    ////////////////////////////////////////////////////////////////////////////

    function automatic region_e region_of(input logic [ADDR_W-1:0] addr);
        if (addr >= SRAM_BASE && addr <= SRAM_BASE + 32'h000F_FFFF) begin
            return REGION_SRAM;
        end else if (addr < ADDR_W'(SCRATCH_WORDS * BE_W)) begin
            return REGION_SCRATCH;
        end
        return REGION_NONE;
    endfunction

    // Legal means mapped and inside the implemented depth
    function automatic logic access_legal(input logic [ADDR_W-1:0] addr);
        case (region_of(addr))
            REGION_SCRATCH: return 1'b1;
            REGION_SRAM:    return (addr - SRAM_BASE) < ADDR_W'(SRAM_WORDS * BE_W);
            default:        return 1'b0;
        endcase
    endfunction

    // Byte offset of the word inside its region
    function automatic int word_offset(input logic [ADDR_W-1:0] addr);
        if (region_of(addr) == REGION_SRAM) begin
            return int'((addr - SRAM_BASE) & 32'hFFFF_FFFC);
        end
        return int'(addr & 32'hFFFF_FFFC);
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        int                base;
        word = '0;
        base = word_offset(addr);
        for (int lane = 0; lane < BE_W; lane++) begin
            if (region_of(addr) == REGION_SRAM) begin
                word[lane*8 +: 8] = sram_bytes[base + lane];
            end else begin
                word[lane*8 +: 8] = scratch_bytes[base + lane];
            end
        end
        return word;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                        input logic [BE_W-1:0]   be,
                                        input logic [DATA_W-1:0] data);
        int base;
        base = word_offset(addr);
        for (int lane = 0; lane < BE_W; lane++) begin
            if (be[lane] && region_of(addr) == REGION_SRAM) begin
                sram_bytes[base + lane] = data[lane*8 +: 8];
            end else if (be[lane]) begin
                scratch_bytes[base + lane] = data[lane*8 +: 8];
            end
        end
    endfunction

    // Initial contents mixed from every address bit
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6B3D_91E7;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic halt_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        halt_on_error();
    endtask

    // Drive one request and note what should come back
    task automatic issue(input logic we, input logic [BE_W-1:0] be,
                         input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        exp_read  = !we;
        exp_err   = !access_legal(addr);
        exp_rdata = '0;
        if (!exp_err && we) begin
            model_write(addr, be, data);
        end else if (!exp_err) begin
            exp_rdata = model_read(addr);
        end
        req_i   = 1'b1;
        we_i    = we;
        be_i    = be;
        addr_i  = addr;
        wdata_i = data;
    endtask

    task automatic check_response();
        int waited;
        waited = 0;
        @(posedge clk_i);
        #1;
        while (rvalid_o !== 1'b1 && waited < RESP_TIMEOUT) begin
            req_i = 1'b0;
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (rvalid_o !== 1'b1) begin
            $display("rvalid_o did not rise within %0d cycles of a request", RESP_TIMEOUT);
            halt_on_error();
        end
        assert (waited == 0) else begin
            $display("Response came %0d cycles later than one cycle after the request", waited);
            halt_on_error();
        end
        assert (err_o === exp_err) else report_mismatch("err_o", DATA_W'(exp_err), DATA_W'(err_o));
        if (exp_read) begin
            assert (rdata_o === exp_rdata) else report_mismatch("rdata_o", exp_rdata, rdata_o);
        end
    endtask

    task automatic single_access(input logic we, input logic [BE_W-1:0] be,
                                 input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        issue(we, be, addr, data);
        check_response();
        req_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]       rnd;
        logic [31:0]       ctl;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] bad_addrs [7];
        void'($urandom(60));
        clk_i     = 1'b0;
        reset_i   = 1'b1;
        req_i     = 1'b1;
        we_i      = 1'b0;
        be_i      = '0;
        addr_i    = 32'h4000_0000;
        wdata_i   = '0;
        exp_read  = 1'b0;
        exp_err   = 1'b0;
        exp_rdata = '0;

        // Unmapped reads held during reset must not answer
        repeat (2) begin
            @(posedge clk_i);
            #1;
            assert (rvalid_o === 1'b0) else report_mismatch("rvalid_o", '0, DATA_W'(rvalid_o));
            assert (err_o === 1'b0) else report_mismatch("err_o", '0, DATA_W'(err_o));
        end
        req_i  = 1'b0;
        addr_i = '0;
        @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Quiet bus after reset
        repeat (4) begin
            assert (rvalid_o === 1'b0) else report_mismatch("rvalid_o", '0, DATA_W'(rvalid_o));
            assert (err_o === 1'b0) else report_mismatch("err_o", '0, DATA_W'(err_o));
            @(posedge clk_i);
            #1;
        end

        // Fill both banks back to back
        for (int w = 0; w < SCRATCH_WORDS; w++) begin
            issue(1'b1, '1, ADDR_W'(w * BE_W), fill_word(ADDR_W'(w * BE_W)));
            check_response();
        end
        for (int w = 0; w < SRAM_WORDS; w++) begin
            addr = SRAM_BASE + ADDR_W'(w * BE_W);
            issue(1'b1, '1, addr, fill_word(addr));
            check_response();
        end
        req_i = 1'b0;

        // Scratch full words first and then partial lanes
        for (int n = 0; n < 16; n++) begin
            rnd  = $urandom;
            addr = {22'd0, rnd[9:2], 2'b00};
            single_access(1'b1, (n < 8) ? 4'hF : rnd[31:28], addr, $urandom);
            single_access(1'b0, '1, addr, '0);
        end

        // Both ends of the SRAM and the scratch word at the same index
        single_access(1'b1, '1, SRAM_BASE, 32'hDEAD_BEEF);
        single_access(1'b1, 4'b0110, SRAM_BASE + ADDR_W'((SRAM_WORDS - 1) * BE_W), 32'hA5A5_0FF0);
        single_access(1'b1, '1, 32'h0000_0000, 32'h1357_9BDF);
        single_access(1'b0, '1, SRAM_BASE, '0);
        single_access(1'b0, '1, SRAM_BASE + ADDR_W'((SRAM_WORDS - 1) * BE_W), '0);
        single_access(1'b0, '1, 32'h0000_0000, '0);

        // Unmapped addresses then SRAM offsets that alias rows 0 and 1023
        bad_addrs = '{32'h4000_0000, 32'h0000_0400, 32'h8010_0000, 32'h7FFF_FFFC,
                      32'h8000_1000, 32'h8000_1FFC, 32'h800F_FFFC};
        foreach (bad_addrs[i]) begin
            single_access(1'b1, '1, bad_addrs[i], 32'hFFFF_FFFF);
            single_access(1'b0, '1, bad_addrs[i], '0);
        end
        single_access(1'b0, '1, SRAM_BASE, '0);
        single_access(1'b0, '1, SRAM_BASE + ADDR_W'((SRAM_WORDS - 1) * BE_W), '0);
        single_access(1'b0, '1, 32'h0000_0000, '0);

        // Random back-to-back traffic over all regions
        for (int n = 0; n < 300; n++) begin
            rnd = $urandom;
            ctl = $urandom;
            case (rnd[1:0])
                2'd0:    addr = {22'd0, rnd[11:4], 2'b00};
                2'd1:    addr = SRAM_BASE | {20'd0, rnd[13:4], 2'b00};
                2'd2:    addr = SRAM_BASE | {12'd0, rnd[21:14] | 8'h01, rnd[13:4], 2'b00};
                default: addr = {2'b01, rnd[31:4], 2'b00};
            endcase
            issue(ctl[0], ctl[4:1], addr, $urandom);
            check_response();
        end
        req_i = 1'b0;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/dmem_pkg.sv
verilog/mem_port_if.sv
verilog/sram_bank.sv
verilog/scratch_ram.sv
verilog/dmem_router.sv
verilog/dmem_top.sv
bench/dmem_props.sv
bench/dmem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data-memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns \
    --top-module dmem_tb \
    -f sources.f \
    -o dmem_sim

./obj_dir/dmem_sim
